// File: hw/mem_pkg.sv
/*
 * shared memory definitions for the console memory subsystem
 * client numbering, address views and the structs passed between
 * the arbiter, the RAM banks, the boot ROM and the return path
 */
`default_nettype none

package mem_pkg;

	localparam int DATA_BITS      = 16;	// one memory word
	localparam int ADDR_BITS      = 16;	// word address
	localparam int NUM_CLIENTS    = 7;	// cpu down to audio
	localparam int NUM_BANKS      = 4;	// picked by top two address bits
	localparam int BANK_ADDR_BITS = 14;	// 16 K words per bank
	localparam int ROM_ADDR_BITS  = 5;	// 32 word boot rom

	typedef logic [$clog2(NUM_CLIENTS)-1:0] client_id_t;
	typedef logic [$clog2(NUM_BANKS)-1:0]   bank_id_t;

	// client numbers double as priority, lowest index wins
	localparam client_id_t CL_CPU    = 3'd0;
	localparam client_id_t CL_SPRITE = 3'd1;
	localparam client_id_t CL_BG0    = 3'd2;
	localparam client_id_t CL_BG1    = 3'd3;
	localparam client_id_t CL_OV     = 3'd4;	// overlay
	localparam client_id_t CL_FLASH  = 3'd5;	// flash loader, writes mostly
	localparam client_id_t CL_AUDIO  = 3'd6;

	// one address word seen as bank + offset or as rom page + index
	typedef union packed
	{
		struct packed
		{
			bank_id_t                  bank;	// top two bits
			logic [BANK_ADDR_BITS-1:0] offset;
		} bank_view;
		struct packed
		{
			logic [ADDR_BITS-ROM_ADDR_BITS-1:0] page;	// page 0 overlays rom
			logic [ROM_ADDR_BITS-1:0]           index;
		} rom_view;
	} mem_addr_u;

	typedef struct packed
	{
		logic                 valid;	// level, held until ready
		logic                 wr;	// 1 write, 0 read
		mem_addr_u            addr;
		logic [DATA_BITS-1:0] wdata;
	} mem_req_t;

	typedef struct packed
	{
		logic                 ready;	// single cycle pulse
		logic [DATA_BITS-1:0] rdata;	// only valid with ready on a read
	} mem_rsp_t;

	typedef struct packed
	{
		logic                      en;	// access strobe
		logic                      wr;
		logic [BANK_ADDR_BITS-1:0] offset;
		logic [DATA_BITS-1:0]      wdata;
	} bank_cmd_t;

	// what was issued last cycle, consumed by the return path
	typedef struct packed
	{
		logic       valid;
		client_id_t client;
		bank_id_t   bank;
		logic       rom_hit;	// cpu read of rom page 0
	} issue_t;

endpackage

`default_nettype wire

// File: hw/mem_arbiter.sv
/*
 * memory arbiter, request side of the controller
 * picks one valid client per cycle by fixed priority and strobes its bank
 */
`default_nettype none

module mem_arbiter
(
	input  wire mem_pkg::mem_req_t            req [mem_pkg::NUM_CLIENTS],
	input  wire logic                         CLK,
	input  wire logic                         rst,
	output mem_pkg::bank_cmd_t                bank_cmd [mem_pkg::NUM_BANKS],
	output mem_pkg::issue_t                   issue,
	output logic [mem_pkg::ROM_ADDR_BITS-1:0] rom_index
);
	import mem_pkg::*;

	logic                 win_found;	// some client gets this slot
	client_id_t           win_client;
	mem_req_t             win_req;	// request of the winner
	mem_addr_u            win_addr;
	logic                 win_rom_hit;
	logic [NUM_BANKS-1:0] bank_en;	// one hot or idle

	// priority search from the cpu downward
	// the client issued last cycle still shows valid during its ready, so skip it
	always_comb
	begin
		win_found  = 1'b0;
		win_client = CL_CPU;
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			if (!win_found && req[i].valid &&
				!(issue.valid && (issue.client == client_id_t'(i))))
			begin
				win_found  = 1'b1;
				win_client = client_id_t'(i);
			end
		end
	end

	// decode the winning address both ways
	always_comb
	begin
		win_req     = req[win_client];
		win_addr    = win_req.addr;
		win_rom_hit = win_found && (win_client == CL_CPU) && !win_req.wr &&
			(win_addr.rom_view.page == '0);	// rom shadows reads only
		rom_index   = win_addr.rom_view.index;	// rom reads every cycle anyway
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			bank_en[b]         = win_found && (win_addr.bank_view.bank == bank_id_t'(b));
			bank_cmd[b].en     = bank_en[b];
			bank_cmd[b].wr     = win_req.wr;	// shared, en qualifies
			bank_cmd[b].offset = win_addr.bank_view.offset;
			bank_cmd[b].wdata  = win_req.wdata;
		end
	end

	// issue record lines up with the registered bank and rom outputs
	always_ff @(posedge CLK)
	begin
		if (rst)
			issue <= '0;
		else
		begin
			issue.valid   <= win_found;
			issue.client  <= win_client;
			issue.bank    <= win_addr.bank_view.bank;
			issue.rom_hit <= win_rom_hit;
		end
	end

	// never more than one bank strobed in a cycle
	a_one_bank: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(bank_en));

	// a client still holding valid in its ready cycle is not issued again
	a_no_repeat: assert property (@(posedge CLK) disable iff (rst)
		(issue.valid && $past(issue.valid)) |-> (issue.client != $past(issue.client)));

endmodule

`default_nettype wire

// File: hw/mem_bank.sv
/*
 * single port RAM bank, 16 K words
 * synchronous write, registered read data held between reads
 */
`default_nettype none

module mem_bank
(
	input  wire logic                     CLK,
	input  wire mem_pkg::bank_cmd_t       cmd,
	output logic [mem_pkg::DATA_BITS-1:0] rdata
);
	import mem_pkg::*;

	logic [DATA_BITS-1:0] mem [1 << BANK_ADDR_BITS];	// powers up undefined

	always_ff @(posedge CLK)
	begin
		if (cmd.en)
		begin
			if (cmd.wr)
				mem[cmd.offset] <= cmd.wdata;
			else
				rdata <= mem[cmd.offset];	// old word kept until next read
		end
	end

	// client write data reaches the bank fully defined
	a_wdata_known: assert property (@(posedge CLK)
		(cmd.en && cmd.wr) |-> !$isunknown(cmd.wdata));

endmodule

`default_nettype wire

// File: hw/boot_rom.sv
/*
 * boot ROM, 32 words overlaying the bottom of the cpu address space
 * contents loaded from a hex image, read every cycle into a register
 */
`default_nettype none

module boot_rom
(
	input  wire logic                              CLK,
	input  wire logic [mem_pkg::ROM_ADDR_BITS-1:0] index,
	output logic [mem_pkg::DATA_BITS-1:0]          rdata
);
	import mem_pkg::*;

	logic [DATA_BITS-1:0] rom [1 << ROM_ADDR_BITS];

	initial
	begin
		$readmemh("hw/boot_rom.mem", rom);	// path from the run directory
	end

	always_ff @(posedge CLK)
	begin
		rdata <= rom[index];	// no enable, return path picks it or not
	end

endmodule

`default_nettype wire

// File: hw/read_return.sv
/*
 * read return path
 * steers bank or rom data to the client issued last cycle and raises its ready
 */
`default_nettype none

module read_return
(
	input  wire mem_pkg::issue_t                   issue,
	input  wire logic [mem_pkg::DATA_BITS-1:0]     bank_rdata [mem_pkg::NUM_BANKS],
	input  wire logic [mem_pkg::DATA_BITS-1:0]     rom_rdata,
	output mem_pkg::mem_rsp_t                      rsp [mem_pkg::NUM_CLIENTS]
);
	import mem_pkg::*;

	logic [DATA_BITS-1:0]   rdata_sel;	// word for the issued client
	logic [NUM_CLIENTS-1:0] ready_vec;

	// rom overlay wins on a cpu page 0 read and the bank word is dropped
	always_comb
	begin
		rdata_sel = issue.rom_hit ? rom_rdata : bank_rdata[issue.bank];
	end

	always_comb
	begin
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			ready_vec[i] = issue.valid && (issue.client == client_id_t'(i));
			rsp[i].ready = ready_vec[i];
			rsp[i].rdata = rdata_sel;	// same word to every client and ready marks the owner
		end
	end

	// checks on what the arbiter registered
	always_comb
	begin
		if (!$isunknown(issue))
		begin
			a_one_ready: assert ($onehot0(ready_vec))
				else $error("more than one client ready");
		end
	end

endmodule

`default_nettype wire

// File: hw/memory_controller.sv
/*
 * shared memory controller of the console
 * arbiter, four RAM banks, boot ROM overlay and the read return path
 */
`default_nettype none

module memory_controller
(
	input  wire logic              CLK,
	input  wire logic              rst,
	input  wire mem_pkg::mem_req_t req [mem_pkg::NUM_CLIENTS],
	output mem_pkg::mem_rsp_t      rsp [mem_pkg::NUM_CLIENTS]
);
	import mem_pkg::*;

	bank_cmd_t                bank_cmd [NUM_BANKS];	// arbiter to banks
	issue_t                   issue;	// arbiter to return path
	logic [ROM_ADDR_BITS-1:0] rom_index;
	logic [DATA_BITS-1:0]     bank_rdata [NUM_BANKS];	// registered bank words
	logic [DATA_BITS-1:0]     rom_rdata;

	mem_arbiter u_mem_arbiter
	(
		.req       (req),
		.CLK       (CLK),
		.rst       (rst),
		.bank_cmd  (bank_cmd),
		.issue     (issue),
		.rom_index (rom_index)
	);

	// bank n holds addresses with top bits n
	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		mem_bank u_mem_bank
		(
			.CLK   (CLK),
			.cmd   (bank_cmd[b]),
			.rdata (bank_rdata[b])
		);
	end

	boot_rom u_boot_rom
	(
		.CLK   (CLK),
		.index (rom_index),
		.rdata (rom_rdata)
	);

	read_return u_read_return
	(
		.issue      (issue),
		.bank_rdata (bank_rdata),
		.rom_rdata  (rom_rdata),
		.rsp        (rsp)
	);

endmodule

`default_nettype wire

// File: tests/tb_vectors.svh
/*
 * directed rows for the memory controller testbench
 * client mask, write flag, one address per client (cpu first) and write data base
 */

typedef struct packed
{
	logic [NUM_CLIENTS-1:0]                mask;	// bit i set, client i requests
	logic                                  wr;	// whole row writes or reads
	logic [0:NUM_CLIENTS-1][ADDR_BITS-1:0] addr;	// indexed by client number
	logic [DATA_BITS-1:0]                  data;	// per client data derived from it
} vec_t;

localparam int NUM_VECS = 23;

localparam vec_t VECS [NUM_VECS] = '{
	'{7'h02, 1'b1, '{16'h0000, 16'h0040, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h1234},	// sprite write, bank 0
	'{7'h02, 1'b0, '{16'h0000, 16'h0040, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	'{7'h04, 1'b1, '{16'h0000, 16'h0000, 16'h4abc, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h5a5a},	// bg0, bank 1
	'{7'h04, 1'b0, '{16'h0000, 16'h0000, 16'h4abc, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	'{7'h40, 1'b1, '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h8001}, 16'hc3c3},	// audio, bank 2
	'{7'h40, 1'b0, '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h8001}, 16'h0000},
	'{7'h20, 1'b1, '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'hfffe, 16'h0000}, 16'h0f0f},	// flash, bank 3
	'{7'h20, 1'b0, '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'hfffe, 16'h0000}, 16'h0000},
	'{7'h02, 1'b1, '{16'h0000, 16'h0003, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'hdead},	// bank word under the rom
	'{7'h01, 1'b1, '{16'h001f, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'hbeef},	// cpu write into page 0
	'{7'h01, 1'b0, '{16'h0003, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},	// rom word expected
	'{7'h01, 1'b0, '{16'h001f, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	'{7'h02, 1'b0, '{16'h0000, 16'h0003, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},	// bank word expected
	'{7'h08, 1'b0, '{16'h0000, 16'h0000, 16'h0000, 16'h001f,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	'{7'h01, 1'b1, '{16'h0020, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h6c6c},	// page 1, no overlay
	'{7'h01, 1'b0, '{16'h0020, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	'{7'h7f, 1'b1, '{16'h1000, 16'h5000, 16'h9000, 16'hd000,
		16'h1001, 16'h5001, 16'h9001}, 16'h7700},	// all seven at once
	'{7'h7f, 1'b0, '{16'h1000, 16'h5000, 16'h9000, 16'hd000,
		16'h1001, 16'h5001, 16'h9001}, 16'h0000},
	'{7'h55, 1'b0, '{16'h0007, 16'h0000, 16'h4abc, 16'h0000,
		16'h1001, 16'h0000, 16'h8001}, 16'h0000},	// cpu rom read in contention
	'{7'h6a, 1'b0, '{16'h0000, 16'h0003, 16'h0000, 16'hd000,
		16'h0000, 16'hfffe, 16'h0040}, 16'h0000},
	'{7'h03, 1'b0, '{16'h0000, 16'h001f, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0000}, 16'h0000},	// rom and bank side by side
	'{7'h1c, 1'b1, '{16'h0000, 16'h0000, 16'h4100, 16'h4101,
		16'h4102, 16'h0000, 16'h0000}, 16'h3c00},	// three hits on bank 1
	'{7'h1c, 1'b0, '{16'h0000, 16'h0000, 16'h4100, 16'h4101,
		16'h4102, 16'h0000, 16'h0000}, 16'h0000}
};

// File: tests/tb_memory_controller.sv
/*
 * testbench for the shared memory controller
 * directed table, cpu rom sweep and random contention rows with ready order checks
 */
`default_nettype none

module tb_memory_controller;
	import mem_pkg::*;

	`include "tb_vectors.svh"

	localparam int          NUM_RAND    = 6;	// random write and read back pairs
	localparam int          NUM_ROWS    = NUM_VECS + (1 << ROM_ADDR_BITS) + 2 * NUM_RAND;
	localparam int          WDOG_CYCLES = (NUM_ROWS + 4) * 20;
	localparam logic [31:0] SEED        = 32'h1722_3dbe;

	logic     CLK;
	logic     rst;
	mem_req_t req [NUM_CLIENTS];
	mem_rsp_t rsp [NUM_CLIENTS];

	logic [DATA_BITS-1:0] rom_copy [1 << ROM_ADDR_BITS];	// from the same hex image
	logic [DATA_BITS-1:0] shadow [1 << ADDR_BITS];	// every word written so far

	int checks     = 0;
	int data_errs  = 0;
	int order_errs = 0;	// ready from the wrong client or twice
	int miss_errs  = 0;

	memory_controller u_memory_controller
	(
		.CLK (CLK),
		.rst (rst),
		.req (req),
		.rsp (rsp)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	initial
	begin
		#(WDOG_CYCLES * 8);
		$display("watchdog: run did not finish within %0d cycles", WDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// each client writes its own variant of the row data
	function automatic logic [DATA_BITS-1:0] client_wdata(input logic [DATA_BITS-1:0] base,
		input int c);
		return base ^ {4{1'b0, 3'(c)}};
	endfunction

	function automatic logic [DATA_BITS-1:0] expected_word(input client_id_t c,
		input logic [ADDR_BITS-1:0] a);
		if (c == CL_CPU && a[ADDR_BITS-1:ROM_ADDR_BITS] == '0)
			return rom_copy[a[ROM_ADDR_BITS-1:0]];	// rom shadows page 0 for cpu reads
		return shadow[a];
	endfunction

	task automatic check_no_ready(input int row);
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			if (rsp[i].ready)
			begin
				order_errs++;
				$display("ERR %0t unexpected ready from client %0d near row %0d", $time, i, row);
			end
		end
	endtask

	task automatic idle_cycles(input int n, input int row);
		for (int k = 0; k < n; k++)
		begin
			@(posedge CLK);
			for (int i = 0; i < NUM_CLIENTS; i++)
				req[i] <= '0;	// all clients quiet
			@(negedge CLK);
			check_no_ready(row);
		end
	endtask

	task automatic run_row(input vec_t v, input int row);
		int                   order [$];	// expected ready order
		mem_req_t             r;
		int                   want;
		logic [DATA_BITS-1:0] exp_word;
		@(posedge CLK);
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			r = '0;
			if (v.mask[i])
			begin
				r.valid = 1'b1;
				r.wr    = v.wr;
				r.addr  = v.addr[i];
				r.wdata = client_wdata(v.data, i);
				order.push_back(i);	// lowest index served first
				if (v.wr)
					shadow[v.addr[i]] = r.wdata;	// later clients land last
			end
			req[i] <= r;
		end
		// quiet first cycle, then one ready per cycle
		for (int step = 1; step <= order.size() + 1; step++)
		begin
			if (step > 1)
			begin
				@(posedge CLK);
				if (step > 2)
					req[order[step - 3]].valid <= 1'b0;	// served last cycle
			end
			@(negedge CLK);
			if (step == 1)
				check_no_ready(row);
			else
			begin
				want = order[step - 2];
				checks++;
				for (int i = 0; i < NUM_CLIENTS; i++)
				begin
					if (rsp[i].ready && i != want)
					begin
						order_errs++;
						$display("ERR %0t row %0d ready from client %0d, expected client %0d",
							$time, row, i, want);
					end
				end
				if (!rsp[want].ready)
				begin
					miss_errs++;
					$display("client %0d got no ready in cycle %0d of row %0d", want, step, row);
				end
				else if (!v.wr)
				begin
					exp_word = expected_word(client_id_t'(want), v.addr[want]);
					if (rsp[want].rdata !== exp_word)
					begin
						data_errs++;
						$display("ERR %0t row %0d client %0d addr %h read %h expected %h",
							$time, row, want, v.addr[want], rsp[want].rdata, exp_word);
					end
				end
			end
		end
	endtask

	initial
	begin
		vec_t v;
		int   row;
		rst = 1'b1;
		for (int i = 0; i < NUM_CLIENTS; i++)
			req[i] = '0;
		void'($urandom(SEED));
		$readmemh("hw/boot_rom.mem", rom_copy);
		repeat (3) @(posedge CLK);
		rst <= 1'b0;
		idle_cycles(4, 0);	// no ready without a request
		row = 0;
		for (int n = 0; n < NUM_VECS; n++)
		begin
			run_row(VECS[n], row);
			row++;
		end
		// cpu walks the whole rom window back to back
		for (int a = 0; a < (1 << ROM_ADDR_BITS); a++)
		begin
			v = '0;
			v.mask = NUM_CLIENTS'(1 << CL_CPU);
			v.addr[CL_CPU] = ADDR_BITS'(a);
			run_row(v, row);
			row++;
		end
		// random contention, read back by the same clients
		for (int k = 0; k < NUM_RAND; k++)
		begin
			v = '0;
			v.mask = NUM_CLIENTS'($urandom_range(1, (1 << NUM_CLIENTS) - 1));
			v.wr   = 1'b1;
			v.data = DATA_BITS'($urandom);
			for (int i = 0; i < NUM_CLIENTS; i++)
				v.addr[i] = ADDR_BITS'($urandom);
			run_row(v, row);
			row++;
			idle_cycles(int'($urandom_range(0, 2)), row);
			v.wr = 1'b0;
			run_row(v, row);
			row++;
		end
		idle_cycles(3, row);	// catches a stray ready after the last row
		$display("checks %0d, data errors %0d, order errors %0d, missing readies %0d",
			checks, data_errs, order_errs, miss_errs);
		if (data_errs + order_errs + miss_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/boot_rom.mem
// boot image, one 16-bit hex word per line, rom index 0 to 31 in order
3c01
0a40
2421
1000
8c22
0004
ac22
0008
2042
ffff
1440
fffe
3c1d
8000
27bd
fff0
0c00
0010
0000
03e0
2108
24a5
0001
14a0
fffb
3c04
4000
ac80
0e20
1001
fffc
9e37

// File: vlog.f
+incdir+tests
hw/mem_pkg.sv
hw/mem_arbiter.sv
hw/mem_bank.sv
hw/boot_rom.sv
hw/read_return.sv
hw/memory_controller.sv
tests/tb_memory_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory controller testbench with Verilator and runs it
# the log decides pass or fail
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	-f vlog.f \
	--top-module tb_memory_controller \
	-Mdir "$OBJ" -o tb_memory_controller

"./$OBJ/tb_memory_controller" | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
exit 0
